//--- Makefile
TOP := tb_apb_register_block

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

//--- apb_adapter/access_decoder.sv
`timescale 1ns/1ps

module access_decoder #(
  parameter int                REGISTERS    = 4,
  parameter regblk_pkg::addr_t BASE_ADDRESS = 8'h40
) (
  input  logic                 i_access_valid,
  input  logic                 i_access_write,
  input  regblk_pkg::addr_t    i_access_addr,
  output logic [REGISTERS-1:0] o_reg_select,
  output logic [REGISTERS-1:0] o_reg_write
);

  localparam int ADDR_WIDTH  = regblk_pkg::ADDR_WIDTH;
  localparam int INDEX_WIDTH = ADDR_WIDTH - regblk_pkg::WORD_SHIFT;

  // One extra bit catches addresses below the base
  logic [ADDR_WIDTH:0]    offset;
  logic [INDEX_WIDTH-1:0] word_index;
  logic                   below_base;
  logic                   in_range;

  // --------------------------------------------------------------------------
  // Range check
  // --------------------------------------------------------------------------
  assign offset     = {1'b0, i_access_addr} - {1'b0, BASE_ADDRESS};
  assign below_base = offset[ADDR_WIDTH];

  // Low two bits ignored
  assign word_index = offset[ADDR_WIDTH-1:regblk_pkg::WORD_SHIFT];

  assign in_range = !below_base && (int'(word_index) < REGISTERS);

  // --------------------------------------------------------------------------
  // One-hot select and write enables
  // --------------------------------------------------------------------------
  always_comb begin
    o_reg_select = '0;
    for (int i = 0; i < REGISTERS; i++) begin
      if (i_access_valid && in_range && (int'(word_index) == i)) begin
        o_reg_select[i] = 1'b1;
      end
    end
  end

  assign o_reg_write = o_reg_select & {REGISTERS{i_access_write}};

endmodule

//--- apb_adapter/apb_adapter.sv
`timescale 1ns/1ps

module apb_adapter (
  input  logic                i_clk,
  input  logic                i_rst_n,
  // APB completer side
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  regblk_pkg::addr_t   i_paddr,
  input  regblk_pkg::data_t   i_pwdata,
  input  regblk_pkg::strobe_t i_pstrb,
  output logic                o_pready,
  output regblk_pkg::data_t   o_prdata,
  output logic                o_pslverr,
  // Response from the read collector
  input  regblk_pkg::data_t   i_resp_rdata,
  input  regblk_pkg::status_t i_resp_status,
  // Internal access
  output logic                o_access_valid,
  output logic                o_access_write,
  output regblk_pkg::addr_t   o_access_addr,
  output regblk_pkg::data_t   o_access_wdata,
  output regblk_pkg::strobe_t o_access_strobe
);

  logic pready_q;
  logic access_valid;

  // Setup phase of a transfer that has not been answered yet
  assign access_valid = i_psel && !i_penable && !pready_q;

  assign o_access_valid  = access_valid;
  assign o_access_write  = i_pwrite;
  assign o_access_addr   = i_paddr;
  assign o_access_wdata  = i_pwdata;
  assign o_access_strobe = i_pstrb;

  // --------------------------------------------------------------------------
  // Access phase completes one cycle after setup
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      pready_q <= 1'b0;
    end else begin
      pready_q <= access_valid;
    end
  end

  // Response captured on the same edge that raises pready
  always_ff @(posedge i_clk) begin
    if (access_valid) begin
      o_prdata  <= i_resp_rdata;
      o_pslverr <= i_resp_status[regblk_pkg::SLVERR_BIT];
    end
  end

  assign o_pready = pready_q;

endmodule

//--- common/regblk_pkg.sv
package regblk_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int ADDR_WIDTH   = 8;
  localparam int DATA_WIDTH   = 32;
  localparam int BYTE_WIDTH   = 8;
  localparam int STROBE_WIDTH = DATA_WIDTH / BYTE_WIDTH;
  localparam int STATUS_WIDTH = 2;
  localparam int FIELD_WIDTH  = 16;

  // Control field sits in the upper half word, status in the lower
  localparam int CTRL_LSB   = 16;
  localparam int STATUS_LSB = 0;

  // Word offset within the byte address
  localparam int WORD_SHIFT = 2;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------
  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [STROBE_WIDTH-1:0] strobe_t;
  typedef logic [STATUS_WIDTH-1:0] status_t;
  typedef logic [FIELD_WIDTH-1:0]  field_t;

  // --------------------------------------------------------------------------
  // Response codes
  // --------------------------------------------------------------------------
  localparam status_t STATUS_OKAY   = 2'b00;
  localparam status_t STATUS_SLVERR = 2'b10;

  // Bit of status_t that goes out on pslverr
  localparam int SLVERR_BIT = 1;

endpackage

//--- flist.f
common/regblk_pkg.sv
apb_adapter/apb_adapter.sv
apb_adapter/access_decoder.sv
hdl/ctrl_status_register.sv
hdl/read_collector.sv
hdl/apb_register_block.sv
tb/apb_checker.sv
tb/tb_apb_register_block.sv

//--- hdl/apb_register_block.sv
`timescale 1ns/1ps

module apb_register_block #(
  parameter int                REGISTERS    = 4,
  parameter regblk_pkg::addr_t BASE_ADDRESS = 8'h40,
  parameter bit                ERROR_STATUS = 1
) (
  input  logic                               i_clk,
  input  logic                               i_rst_n,
  // APB
  input  logic                               i_psel,
  input  logic                               i_penable,
  input  logic                               i_pwrite,
  input  regblk_pkg::addr_t                  i_paddr,
  input  regblk_pkg::data_t                  i_pwdata,
  input  regblk_pkg::strobe_t                i_pstrb,
  output logic                               o_pready,
  output regblk_pkg::data_t                  o_prdata,
  output logic                               o_pslverr,
  // Hardware side
  input  regblk_pkg::field_t [REGISTERS-1:0] i_hw_set,
  output regblk_pkg::field_t [REGISTERS-1:0] o_ctrl
);

  logic                              access_valid;
  logic                              access_write;
  regblk_pkg::addr_t                 access_addr;
  regblk_pkg::data_t                 access_wdata;
  regblk_pkg::strobe_t               access_strobe;
  logic [REGISTERS-1:0]              reg_select;
  logic [REGISTERS-1:0]              reg_write;
  regblk_pkg::data_t [REGISTERS-1:0] reg_rdata;
  regblk_pkg::data_t                 resp_rdata;
  regblk_pkg::status_t               resp_status;

  // --------------------------------------------------------------------------
  // Bus side
  // --------------------------------------------------------------------------
  apb_adapter u_apb_adapter (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_psel          (i_psel),
    .i_penable       (i_penable),
    .i_pwrite        (i_pwrite),
    .i_paddr         (i_paddr),
    .i_pwdata        (i_pwdata),
    .i_pstrb         (i_pstrb),
    .o_pready        (o_pready),
    .o_prdata        (o_prdata),
    .o_pslverr       (o_pslverr),
    .i_resp_rdata    (resp_rdata),
    .i_resp_status   (resp_status),
    .o_access_valid  (access_valid),
    .o_access_write  (access_write),
    .o_access_addr   (access_addr),
    .o_access_wdata  (access_wdata),
    .o_access_strobe (access_strobe)
  );

  access_decoder #(
    .REGISTERS    (REGISTERS),
    .BASE_ADDRESS (BASE_ADDRESS)
  ) u_access_decoder (
    .i_access_valid (access_valid),
    .i_access_write (access_write),
    .i_access_addr  (access_addr),
    .o_reg_select   (reg_select),
    .o_reg_write    (reg_write)
  );

  // --------------------------------------------------------------------------
  // Register array
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < REGISTERS; i++) begin : g_register
    ctrl_status_register u_register (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_write  (reg_write[i]),
      .i_wdata  (access_wdata),
      .i_strobe (access_strobe),
      .i_hw_set (i_hw_set[i]),
      .o_ctrl   (o_ctrl[i]),
      .o_rdata  (reg_rdata[i])
    );
  end

  read_collector #(
    .REGISTERS    (REGISTERS),
    .ERROR_STATUS (ERROR_STATUS)
  ) u_read_collector (
    .i_reg_select  (reg_select),
    .i_reg_rdata   (reg_rdata),
    .o_resp_rdata  (resp_rdata),
    .o_resp_status (resp_status)
  );

endmodule

//--- hdl/ctrl_status_register.sv
`timescale 1ns/1ps

module ctrl_status_register (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_write,
  input  regblk_pkg::data_t   i_wdata,
  input  regblk_pkg::strobe_t i_strobe,
  input  regblk_pkg::field_t  i_hw_set,
  output regblk_pkg::field_t  o_ctrl,
  output regblk_pkg::data_t   o_rdata
);

  localparam int BYTE_WIDTH  = regblk_pkg::BYTE_WIDTH;
  localparam int FIELD_WIDTH = regblk_pkg::FIELD_WIDTH;
  localparam int FIELD_BYTES = FIELD_WIDTH / BYTE_WIDTH;
  localparam int CTRL_BYTE   = regblk_pkg::CTRL_LSB / BYTE_WIDTH;
  localparam int STATUS_BYTE = regblk_pkg::STATUS_LSB / BYTE_WIDTH;

  regblk_pkg::field_t ctrl_q;
  regblk_pkg::field_t status_q;
  regblk_pkg::field_t ctrl_mask;
  regblk_pkg::field_t status_mask;
  regblk_pkg::field_t ctrl_wdata;
  regblk_pkg::field_t status_wdata;
  regblk_pkg::field_t status_clear;

  assign ctrl_wdata   = i_wdata[regblk_pkg::CTRL_LSB+:FIELD_WIDTH];
  assign status_wdata = i_wdata[regblk_pkg::STATUS_LSB+:FIELD_WIDTH];

  // Byte strobes widened to bit masks per field
  always_comb begin
    for (int b = 0; b < FIELD_BYTES; b++) begin
      ctrl_mask[b*BYTE_WIDTH+:BYTE_WIDTH]   = {BYTE_WIDTH{i_strobe[CTRL_BYTE+b]}};
      status_mask[b*BYTE_WIDTH+:BYTE_WIDTH] = {BYTE_WIDTH{i_strobe[STATUS_BYTE+b]}};
    end
  end

  // --------------------------------------------------------------------------
  // Control field, read/write
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      ctrl_q <= '0;
    end else if (i_write) begin
      ctrl_q <= (ctrl_q & ~ctrl_mask) | (ctrl_wdata & ctrl_mask);
    end
  end

  // --------------------------------------------------------------------------
  // Status field, sticky, write one to clear
  // --------------------------------------------------------------------------
  assign status_clear = i_write ? (status_wdata & status_mask) : '0;

  // Hardware set applied after the clear so set wins
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clear) | i_hw_set;
    end
  end

  assign o_ctrl  = ctrl_q;
  assign o_rdata = {ctrl_q, status_q};

endmodule

//--- hdl/read_collector.sv
`timescale 1ns/1ps

module read_collector #(
  parameter int REGISTERS    = 4,
  parameter bit ERROR_STATUS = 1
) (
  input  logic [REGISTERS-1:0]              i_reg_select,
  input  regblk_pkg::data_t [REGISTERS-1:0] i_reg_rdata,
  output regblk_pkg::data_t                 o_resp_rdata,
  output regblk_pkg::status_t               o_resp_status
);

  localparam int DATA_WIDTH = regblk_pkg::DATA_WIDTH;

  logic hit;

  // --------------------------------------------------------------------------
  // Read data, AND-OR mux over the one-hot select
  // --------------------------------------------------------------------------
  always_comb begin
    o_resp_rdata = '0;
    for (int i = 0; i < REGISTERS; i++) begin
      o_resp_rdata = o_resp_rdata | (i_reg_rdata[i] & {DATA_WIDTH{i_reg_select[i]}});
    end
  end

  // --------------------------------------------------------------------------
  // Response status
  // --------------------------------------------------------------------------
  assign hit = |i_reg_select;

  // Empty select means the access missed every register
  always_comb begin
    if (hit) begin
      o_resp_status = regblk_pkg::STATUS_OKAY;
    end else if (ERROR_STATUS) begin
      o_resp_status = regblk_pkg::STATUS_SLVERR;
    end else begin
      o_resp_status = regblk_pkg::STATUS_OKAY;
    end
  end

endmodule

//--- tb/apb_checker.sv
`timescale 1ns/1ps

module apb_checker #(
  parameter int REGISTERS = 4
) (
  input  logic                                           i_clk,
  input  logic                                           i_rst_n,
  input  logic                                           i_psel,
  input  logic                                           i_penable,
  input  logic                                           i_pwrite,
  input  regblk_pkg::addr_t                              i_paddr,
  input  regblk_pkg::data_t                              i_pwdata,
  input  regblk_pkg::strobe_t                            i_pstrb,
  input  logic                                           i_pready,
  input  regblk_pkg::data_t                              i_prdata,
  input  logic                                           i_pslverr,
  input  regblk_pkg::field_t [REGISTERS-1:0]             i_hw_set,
  input  regblk_pkg::field_t [REGISTERS-1:0]             i_ctrl,
  // Expected values from the stimulus table
  input  int                                             i_entry_index,
  input  logic [1:0]                                     i_entry_op,
  input  regblk_pkg::data_t                              i_exp_rdata,
  input  logic                                           i_exp_pslverr,
  input  logic [REGISTERS*regblk_pkg::FIELD_WIDTH-1:0]   i_exp_ctrl,
  input  logic                                           i_entry_done,
  output int                                             o_passed,
  output int                                             o_failed
);

  localparam logic [1:0] OP_READ   = 2'd0;
  localparam logic [1:0] OP_WRITE  = 2'd1;
  localparam logic [1:0] OP_HW_SET = 2'd2;

  int                                 entry_errors = 0;
  int                                 completions = 0;
  int                                 expected_completions;
  int                                 passed_count = 0;
  int                                 failed_count = 0;
  logic                               setup_q = 1'b0;
  regblk_pkg::addr_t                  setup_addr = '0;
  logic                               setup_write = 1'b0;
  regblk_pkg::data_t                  setup_wdata = '0;
  regblk_pkg::strobe_t                setup_strb = '0;
  regblk_pkg::field_t [REGISTERS-1:0] hw_seen = '0;

  assign o_passed = passed_count;
  assign o_failed = failed_count;

  task automatic report_mismatch(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
    $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
    entry_errors++;
  endtask

  function automatic string op_name(input logic [1:0] op);
    if (op == OP_READ) begin
      return "read";
    end else if (op == OP_WRITE) begin
      return "write";
    end
    return "hw_set";
  endfunction

  // --------------------------------------------------------------------------
  // Sampled on the rising edge with the values of the cycle just ended
  // --------------------------------------------------------------------------
  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      setup_q <= 1'b0;
    end else begin
      // pready only in the cycle right after a setup cycle
      if (i_pready !== setup_q) begin
        $display("Protocol error at t=%0t: pready was %b after a cycle that %s a setup",
                 $time, i_pready, setup_q ? "was" : "was not");
        entry_errors++;
      end
      setup_q <= i_psel && !i_penable;
      if (i_psel && !i_penable) begin
        setup_addr  <= i_paddr;
        setup_write <= i_pwrite;
        setup_wdata <= i_pwdata;
        setup_strb  <= i_pstrb;
      end
      if (|i_hw_set) begin
        hw_seen <= i_hw_set;
      end

      if (i_pready) begin
        completions++;
        if (i_prdata !== i_exp_rdata) begin
          report_mismatch("prdata", i_exp_rdata, i_prdata);
        end
        if (i_pslverr !== i_exp_pslverr) begin
          report_mismatch("pslverr", i_exp_pslverr, i_pslverr);
        end
      end

      if (i_entry_done) begin
        if (i_ctrl !== i_exp_ctrl) begin
          report_mismatch("o_ctrl", i_exp_ctrl, i_ctrl);
        end
        expected_completions = (i_entry_op == OP_HW_SET) ? 0 : 1;
        if (completions != expected_completions) begin
          $display("Entry %0d saw %0d completed transfers instead of %0d",
                   i_entry_index, completions, expected_completions);
          entry_errors++;
        end
        if (i_entry_op == OP_HW_SET) begin
          $display("entry %0d %s %h: %s", i_entry_index, op_name(i_entry_op), hw_seen,
                   (entry_errors == 0) ? "ok" : "FAILED");
        end else if (setup_write) begin
          $display("entry %0d %s %h data %h strobe %b: %s", i_entry_index,
                   op_name(i_entry_op), setup_addr, setup_wdata, setup_strb,
                   (entry_errors == 0) ? "ok" : "FAILED");
        end else begin
          $display("entry %0d %s %h: %s", i_entry_index, op_name(i_entry_op), setup_addr,
                   (entry_errors == 0) ? "ok" : "FAILED");
        end
        if (entry_errors == 0) begin
          passed_count++;
        end else begin
          failed_count++;
        end
        entry_errors = 0;
        completions  = 0;
      end
    end
  end

endmodule

//--- tb/tb_apb_register_block.sv
`timescale 1ns/1ps

module tb_apb_register_block;

  localparam int         REGISTERS  = 4;
  localparam int         CTRL_WIDTH = REGISTERS * regblk_pkg::FIELD_WIDTH;
  localparam logic [1:0] OP_READ    = 2'd0;
  localparam logic [1:0] OP_WRITE   = 2'd1;
  localparam logic [1:0] OP_HW_SET  = 2'd2;

  typedef struct packed {
    logic [1:0]            op;
    regblk_pkg::addr_t     addr;
    regblk_pkg::data_t     wdata;
    regblk_pkg::strobe_t   strb;
    int                    hw_index;
    regblk_pkg::field_t    hw_value;
    regblk_pkg::data_t     exp_rdata;
    logic                  exp_pslverr;
    logic [CTRL_WIDTH-1:0] exp_ctrl;
  } entry_t;

  entry_t entries[$];

  logic                               clk;
  logic                               rst_n;
  logic                               psel;
  logic                               penable;
  logic                               pwrite;
  regblk_pkg::addr_t                  paddr;
  regblk_pkg::data_t                  pwdata;
  regblk_pkg::strobe_t                pstrb;
  logic                               pready;
  regblk_pkg::data_t                  prdata;
  logic                               pslverr;
  regblk_pkg::field_t [REGISTERS-1:0] hw_set;
  regblk_pkg::field_t [REGISTERS-1:0] ctrl;

  // Expected values of the entry in progress
  int                    entry_index;
  logic [1:0]            cur_op;
  regblk_pkg::data_t     exp_rdata;
  logic                  exp_pslverr;
  logic [CTRL_WIDTH-1:0] exp_ctrl;
  logic                  entry_done;
  int                    passed;
  int                    failed;

  apb_register_block #(
    .REGISTERS (REGISTERS)
  ) i_dut (
    .i_clk     (clk),
    .i_rst_n   (rst_n),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .i_pstrb   (pstrb),
    .o_pready  (pready),
    .o_prdata  (prdata),
    .o_pslverr (pslverr),
    .i_hw_set  (hw_set),
    .o_ctrl    (ctrl)
  );

  apb_checker #(
    .REGISTERS (REGISTERS)
  ) u_checker (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_psel        (psel),
    .i_penable     (penable),
    .i_pwrite      (pwrite),
    .i_paddr       (paddr),
    .i_pwdata      (pwdata),
    .i_pstrb       (pstrb),
    .i_pready      (pready),
    .i_prdata      (prdata),
    .i_pslverr     (pslverr),
    .i_hw_set      (hw_set),
    .i_ctrl        (ctrl),
    .i_entry_index (entry_index),
    .i_entry_op    (cur_op),
    .i_exp_rdata   (exp_rdata),
    .i_exp_pslverr (exp_pslverr),
    .i_exp_ctrl    (exp_ctrl),
    .i_entry_done  (entry_done),
    .o_passed      (passed),
    .o_failed      (failed)
  );

  // --------------------------------------------------------------------------
  // Stimulus table
  // --------------------------------------------------------------------------
  function automatic void add_read(input regblk_pkg::addr_t addr,
                                   input regblk_pkg::data_t rdata, input logic err,
                                   input logic [CTRL_WIDTH-1:0] ctrl_value);
    entry_t e;
    e = '0;
    e.op          = OP_READ;
    e.addr        = addr;
    e.exp_rdata   = rdata;
    e.exp_pslverr = err;
    e.exp_ctrl    = ctrl_value;
    entries.push_back(e);
  endfunction

  // A write returns the register value from before the write
  function automatic void add_write(input regblk_pkg::addr_t addr,
                                    input regblk_pkg::data_t wdata,
                                    input regblk_pkg::strobe_t strb,
                                    input regblk_pkg::data_t rdata, input logic err,
                                    input logic [CTRL_WIDTH-1:0] ctrl_value);
    entry_t e;
    e = '0;
    e.op          = OP_WRITE;
    e.addr        = addr;
    e.wdata       = wdata;
    e.strb        = strb;
    e.exp_rdata   = rdata;
    e.exp_pslverr = err;
    e.exp_ctrl    = ctrl_value;
    entries.push_back(e);
  endfunction

  function automatic void add_hw_set(input int index, input regblk_pkg::field_t value,
                                     input logic [CTRL_WIDTH-1:0] ctrl_value);
    entry_t e;
    e = '0;
    e.op       = OP_HW_SET;
    e.hw_index = index;
    e.hw_value = value;
    e.exp_ctrl = ctrl_value;
    entries.push_back(e);
  endfunction

  // Control fields packed as {reg3, reg2, reg1, reg0}
  function automatic void build_table();
    // Everything zero after reset
    add_read(8'h40, 32'h0000_0000, 1'b0, 64'h0000_0000_0000_0000);
    add_read(8'h44, 32'h0000_0000, 1'b0, 64'h0000_0000_0000_0000);
    add_read(8'h48, 32'h0000_0000, 1'b0, 64'h0000_0000_0000_0000);
    add_read(8'h4C, 32'h0000_0000, 1'b0, 64'h0000_0000_0000_0000);
    // Control field with full and partial strobes
    add_write(8'h40, 32'h1234_0000, 4'b1111, 32'h0000_0000, 1'b0, 64'h0000_0000_0000_1234);
    add_read(8'h40, 32'h1234_0000, 1'b0, 64'h0000_0000_0000_1234);
    add_write(8'h44, 32'hABCD_0000, 4'b1000, 32'h0000_0000, 1'b0, 64'h0000_0000_AB00_1234);
    add_read(8'h44, 32'hAB00_0000, 1'b0, 64'h0000_0000_AB00_1234);
    add_write(8'h44, 32'h55EF_0000, 4'b0100, 32'hAB00_0000, 1'b0, 64'h0000_0000_ABEF_1234);
    add_read(8'h44, 32'hABEF_0000, 1'b0, 64'h0000_0000_ABEF_1234);
    add_write(8'h4C, 32'hFFFF_FFFF, 4'b0011, 32'h0000_0000, 1'b0, 64'h0000_0000_ABEF_1234);
    add_read(8'h4C, 32'h0000_0000, 1'b0, 64'h0000_0000_ABEF_1234);
    // Low address bits ignored
    add_write(8'h4A, 32'h8001_0000, 4'b1111, 32'h0000_0000, 1'b0, 64'h0000_8001_ABEF_1234);
    add_read(8'h48, 32'h8001_0000, 1'b0, 64'h0000_8001_ABEF_1234);
    // Sticky status cleared by writing ones
    add_hw_set(1, 16'hF00F, 64'h0000_8001_ABEF_1234);
    add_read(8'h44, 32'hABEF_F00F, 1'b0, 64'h0000_8001_ABEF_1234);
    add_write(8'h44, 32'h0000_FFFF, 4'b0001, 32'hABEF_F00F, 1'b0, 64'h0000_8001_ABEF_1234);
    add_read(8'h44, 32'hABEF_F000, 1'b0, 64'h0000_8001_ABEF_1234);
    add_write(8'h44, 32'h0000_3000, 4'b0010, 32'hABEF_F000, 1'b0, 64'h0000_8001_ABEF_1234);
    add_read(8'h44, 32'hABEF_C000, 1'b0, 64'h0000_8001_ABEF_1234);
    add_hw_set(3, 16'h0101, 64'h0000_8001_ABEF_1234);
    add_read(8'h4C, 32'h0000_0101, 1'b0, 64'h0000_8001_ABEF_1234);
    // Outside the block
    add_read(8'h3C, 32'h0000_0000, 1'b1, 64'h0000_8001_ABEF_1234);
    add_read(8'h50, 32'h0000_0000, 1'b1, 64'h0000_8001_ABEF_1234);
    add_write(8'h50, 32'hFFFF_FFFF, 4'b1111, 32'h0000_0000, 1'b1, 64'h0000_8001_ABEF_1234);
    add_write(8'h3C, 32'hFFFF_FFFF, 4'b1111, 32'h0000_0000, 1'b1, 64'h0000_8001_ABEF_1234);
    add_read(8'h4C, 32'h0000_0101, 1'b0, 64'h0000_8001_ABEF_1234);
    add_read(8'h40, 32'h1234_0000, 1'b0, 64'h0000_8001_ABEF_1234);
    add_read(8'h48, 32'h8001_0000, 1'b0, 64'h0000_8001_ABEF_1234);
    add_read(8'h44, 32'hABEF_C000, 1'b0, 64'h0000_8001_ABEF_1234);
  endfunction

  // --------------------------------------------------------------------------
  // Bus and hardware drivers
  // --------------------------------------------------------------------------
  // Starts on a rising edge and returns on the edge that ends the access cycle
  task automatic run_transfer(input entry_t e);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= (e.op == OP_WRITE);
    paddr   <= e.addr;
    pwdata  <= e.wdata;
    pstrb   <= e.strb;
    @(posedge clk);
    penable <= 1'b1;
    do begin
      @(posedge clk);
    end while (!pready);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic pulse_hw_set(input entry_t e);
    hw_set[e.hw_index] <= e.hw_value;
    @(posedge clk);
    hw_set <= '0;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    pstrb       = '0;
    hw_set      = '0;
    entry_index = 0;
    cur_op      = OP_READ;
    exp_rdata   = '0;
    exp_pslverr = 1'b0;
    exp_ctrl    = '0;
    entry_done  = 1'b0;
    build_table();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int n = 0; n < entries.size(); n++) begin
      entry_index <= n;
      cur_op      <= entries[n].op;
      exp_rdata   <= entries[n].exp_rdata;
      exp_pslverr <= entries[n].exp_pslverr;
      exp_ctrl    <= entries[n].exp_ctrl;
      if (entries[n].op == OP_HW_SET) begin
        pulse_hw_set(entries[n]);
      end else begin
        run_transfer(entries[n]);
      end
      // Idle cycle in which the checker closes the entry
      entry_done <= 1'b1;
      @(posedge clk);
      entry_done <= 1'b0;
    end
    @(posedge clk);
    @(posedge clk);
    $display("%0d entries: %0d passed, %0d failed", entries.size(), passed, failed);
    if (failed == 0 && passed == entries.size()) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Run limit from the table length
  initial begin
    int cycle_limit;
    int cycle_count;
    cycle_count = 0;
    @(posedge clk);
    cycle_limit = entries.size() * 6 + 16 + 50;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Testbench failed");
    $finish;
  end

endmodule
